//--- Makefile
# Verilator build and run of the host command channel testbench

TOP := tb_hps_ext_sys

.PHONY: sim clean

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_vectors.svh
/*
 * host transaction table
 * one row per command with its address and word count, plus the
 * status arguments and expected request replies, two bits per word
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// a row is a full host command, a core event pulse, or a write that is
// dropped after its first address word
typedef enum logic [1:0] {
	kind_cmd,
	kind_irq,
	kind_abort
} vec_kind_t;

typedef struct packed {
	vec_kind_t   kind;
	logic [15:0] cmd;
	logic [31:0] addr;
	logic [7:0]  words;
	logic [7:0]  args;
	logic [7:0]  replies;
} vec_t;

// write data comes from the seeded generator, reads are checked
// against the shadow copy, status replies follow the irq row
vec_t vec_table [12] = '{
	'{kind_cmd,   ext_pkg::ext_cmd_write,  32'h0000_0020, 8'd4, 8'h00, 8'h00},
	'{kind_cmd,   ext_pkg::ext_cmd_read,   32'h0000_0020, 8'd4, 8'h00, 8'h00},
	'{kind_cmd,   ext_pkg::ext_cmd_write,  32'h0000_0044, 8'd4, 8'h00, 8'h00},
	'{kind_cmd,   ext_pkg::ext_cmd_read,   32'h0000_004c, 8'd2, 8'h00, 8'h00},
	'{kind_cmd,   ext_pkg::ext_cmd_read,   32'h0000_0044, 8'd4, 8'h00, 8'h00},
	'{kind_irq,   16'h0000,                32'h0000_0000, 8'd0, 8'h03, 8'h00},
	'{kind_cmd,   ext_pkg::ext_cmd_status, 32'h0000_0000, 8'd2, 8'h01, 8'h0b},
	'{kind_cmd,   16'h0040,                32'h0000_0000, 8'd1, 8'h00, 8'h00},
	'{kind_abort, ext_pkg::ext_cmd_write,  32'h0000_0080, 8'd0, 8'h00, 8'h00},
	'{kind_cmd,   ext_pkg::ext_cmd_write,  32'h0000_0060, 8'd2, 8'h00, 8'h00},
	'{kind_cmd,   ext_pkg::ext_cmd_read,   32'h0000_0060, 8'd2, 8'h00, 8'h00},
	'{kind_cmd,   ext_pkg::ext_cmd_status, 32'h0000_0000, 8'd1, 8'h02, 8'h02}
};

`endif

//--- dv/tb_hps_ext_sys.sv
`timescale 1ns/1ps
/*
 * testbench for the host command channel
 * applies the transaction table to the top level, keeps a shadow copy
 * of core memory and checks every reply the host sees
 */
module tb_hps_ext_sys;

	`include "tb_vectors.svh"

	logic               clk_sys;
	logic               rst;
	ext_pkg::host_req_t host_req;
	ext_pkg::host_rsp_t host_rsp;
	logic [31:0]        clk_rate;
	logic [1:0]         irq;
	logic [1:0]         status;

	// expected core memory, one entry per 32-bit word
	logic [31:0] shadow [ext_pkg::ext_mem_words];
	integer      seed;
	int          value_errs;
	int          other_errs;
	int          cycle_cnt;
	int          cycle_limit;
	// status pulse as seen on the cycle after the last strobe
	logic [1:0]  last_status;

	hps_ext_sys u_dut (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.host_req (host_req),
		.host_rsp (host_rsp),
		.clk_rate (clk_rate),
		.irq      (irq),
		.status   (status)
	);

	always #10 clk_sys = ~clk_sys;

	// the run is cut off once it takes longer than the table allows
	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: the table did not finish within %0d cycles", cycle_limit);
			$display("sim failed");
			$finish;
		end
	end

	// command word, two address words and two halves per data word
	function automatic int table_words();
		int total;
		total = 0;
		foreach (vec_table[i]) begin
			total += 3 + 2 * int'(vec_table[i].words);
		end
		return total;
	endfunction

	task automatic compare_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	// one strobed word followed by an idle cycle, the reply is taken after both
	task automatic send_word(input logic [15:0] word, output logic [15:0] reply);
		host_req.strobe = 1'b1;
		host_req.din = word;
		@(posedge clk_sys);
		#1;
		host_req.strobe = 1'b0;
		// status only lasts for the cycle right after the strobe
		last_status = status;
		@(posedge clk_sys);
		#1;
		reply = host_rsp.dout;
	endtask

	// busy rises a cycle or two after the read strobe and falls with the data
	task automatic wait_read_done();
		int n;
		n = 0;
		while (!host_rsp.busy && n < 8) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (!host_rsp.busy) begin
			$display("busy never rose after a read strobe");
			other_errs++;
		end
		while (host_rsp.busy) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic run_row(input int idx, input vec_t v);
		logic [15:0] reply;
		logic [31:0] data;
		logic [7:0]  widx;
		logic [1:0]  arg;
		logic        known;
		known = (v.cmd == ext_pkg::ext_cmd_write) || (v.cmd == ext_pkg::ext_cmd_read) ||
			(v.cmd == ext_pkg::ext_cmd_status);
		widx = v.addr[9:2];
		if (v.kind == kind_irq) begin
			irq = v.args[1:0];
			@(posedge clk_sys);
			#1;
			irq = 2'b00;
			@(posedge clk_sys);
			#1;
		end else begin
			// alternate between the enable bits, either one opens the channel
			host_req.enable = idx[0] ? 2'b10 : 2'b01;
			@(posedge clk_sys);
			#1;
			send_word(v.cmd, reply);
			compare_value("host_rsp.dout_en", {15'd0, host_rsp.dout_en}, {15'd0, known});
			if (!known) begin
				compare_value("host_rsp.dout", reply, 16'd0);
			end
			if (v.cmd == ext_pkg::ext_cmd_write || v.cmd == ext_pkg::ext_cmd_read) begin
				send_word(v.addr[15:0], reply);
				if (v.cmd == ext_pkg::ext_cmd_write) begin
					compare_value("host_rsp.dout", reply, clk_rate[15:0]);
					compare_value("host_rsp.dout_en", {15'd0, host_rsp.dout_en}, 16'd1);
				end
				if (v.kind == kind_cmd) begin
					send_word(v.addr[31:16], reply);
					if (v.cmd == ext_pkg::ext_cmd_write) begin
						compare_value("host_rsp.dout", reply, clk_rate[31:16]);
						compare_value("host_rsp.dout_en", {15'd0, host_rsp.dout_en}, 16'd1);
					end
				end
			end
			for (int i = 0; v.kind == kind_cmd && i < int'(v.words); i++) begin
				case (v.cmd)
					ext_pkg::ext_cmd_write: begin
						data = $random(seed);
						send_word(data[15:0], reply);
						send_word(data[31:16], reply);
						shadow[widx] = data;
						widx = widx + 8'd1;
					end
					ext_pkg::ext_cmd_read: begin
						send_word(16'h0000, reply);
						wait_read_done();
						compare_value("host_rsp.dout", host_rsp.dout, shadow[widx][15:0]);
						send_word(16'h0000, reply);
						compare_value("host_rsp.dout", reply, shadow[widx][31:16]);
						widx = widx + 8'd1;
					end
					ext_pkg::ext_cmd_status: begin
						arg = 2'(v.args >> (2 * i));
						send_word({14'd0, arg}, reply);
						compare_value("host_rsp.dout", reply, {14'd0, 2'(v.replies >> (2 * i))});
						compare_value("status", {14'd0, last_status}, {14'd0, arg});
					end
					default: begin
						send_word(i[15:0], reply);
						compare_value("host_rsp.dout", reply, 16'd0);
						compare_value("host_rsp.dout_en", {15'd0, host_rsp.dout_en}, 16'd0);
					end
				endcase
			end
			host_req.enable = 2'b00;
			@(posedge clk_sys);
			#1;
			// with enable low the reply is cleared for the next command
			compare_value("host_rsp.dout_en", {15'd0, host_rsp.dout_en}, 16'd0);
			compare_value("host_rsp.dout", host_rsp.dout, 16'd0);
		end
	endtask

	initial begin
		clk_sys = 1'b0;
		rst = 1'b1;
		host_req = '0;
		clk_rate = 32'h05f5_e100;
		irq = 2'b00;
		seed = 32'h8e43;
		value_errs = 0;
		other_errs = 0;
		cycle_cnt = 0;
		last_status = 2'b00;
		cycle_limit = 40 * table_words() + 200;
		repeat (2) @(posedge clk_sys);
		#1;
		rst = 1'b0;
		// host side of the channel comes out of reset idle
		compare_value("host_rsp.dout", host_rsp.dout, 16'd0);
		compare_value("host_rsp.dout_en", {15'd0, host_rsp.dout_en}, 16'd0);
		compare_value("host_rsp.busy", {15'd0, host_rsp.busy}, 16'd0);
		compare_value("status", {14'd0, status}, 16'd0);
		foreach (vec_table[i]) begin
			run_row(i, vec_table[i]);
		end
		$display("done: %0d value errors, %0d other errors", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- verilog/ext_mem.sv
`timescale 1ns/1ps
/*
 * core-side word memory
 * 32-bit words written on the wr pulse, reads stretched by a wait
 * level whose length depends on address bits 3:2
 */
module ext_mem (
	input  logic              clk_sys,
	input  logic              rst,
	input  ext_pkg::ext_bus_t ext_bus,
	output logic [31:0]       rdata,
	output logic              mem_wait
);

	logic [31:0] mem [ext_pkg::ext_mem_words];

	// word index taken from the byte address
	logic [ext_pkg::ext_mem_aw-1:0] waddr;
	// index of the read in flight
	logic [ext_pkg::ext_mem_aw-1:0] rd_addr;
	// remaining wait cycles, at most four
	logic [2:0] wait_cnt;
	logic       wait_last;

	assign waddr = ext_bus.addr[ext_pkg::ext_mem_aw+1:2];

	// the final wait cycle is the one that presents the word
	assign wait_last = (wait_cnt == 3'd1);

	// write takes effect on the wr cycle itself
	always_ff @(posedge clk_sys) begin
		if (ext_bus.wr) begin
			mem[waddr] <= ext_bus.dout;
		end
	end

	// wait sequencing
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wait_cnt <= 3'd0;
			mem_wait <= 1'b0;
		end else if (ext_bus.rd) begin
			// one cycle plus the word position inside a 16-byte line
			wait_cnt <= {1'b0, ext_bus.addr[3:2]} + 3'd1;
			mem_wait <= 1'b1;
		end else if (wait_cnt != 3'd0) begin
			wait_cnt <= wait_cnt - 3'd1;
			if (wait_last) begin
				mem_wait <= 1'b0;
			end
		end
	end

	// read address capture and data output
	always_ff @(posedge clk_sys) begin
		if (ext_bus.rd) begin
			rd_addr <= waddr;
		end
		// the word appears together with the fall of wait and then holds
		// until the next read completes
		if (wait_last) begin
			rdata <= mem[rd_addr];
		end
	end

endmodule

//--- verilog/ext_pkg.sv
/*
 * host command channel shared definitions
 * command codes, core memory geometry and the packed buses between
 * the host, the command decoder and the core-side memory
 */
package ext_pkg;

	// host command codes, one per supported transfer type
	localparam logic [15:0] ext_cmd_write  = 16'h0061;
	localparam logic [15:0] ext_cmd_read   = 16'h0062;
	localparam logic [15:0] ext_cmd_status = 16'h0063;

	// a command word outside this range is not answered
	localparam logic [15:0] ext_cmd_min = ext_cmd_write;
	localparam logic [15:0] ext_cmd_max = ext_cmd_status;

	// core memory holds 32-bit words, indexed by byte address bits 9:2
	localparam int ext_mem_words = 256;
	localparam int ext_mem_aw    = 8;

	// host to decoder, one word per cycle with strobe high
	// the channel counts as active while either enable bit is set
	typedef struct packed {
		logic [1:0]  enable;
		logic        strobe;
		logic [15:0] din;
	} host_req_t;

	// decoder to host, busy follows the core wait level
	typedef struct packed {
		logic [15:0] dout;
		logic        dout_en;
		logic        busy;
	} host_rsp_t;

	// decoder to core memory, rd and wr are single-cycle pulses
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] dout;
		logic        rd;
		logic        wr;
	} ext_bus_t;

endpackage

//--- verilog/ext_req_reg.sv
`timescale 1ns/1ps
/*
 * core request register
 * one sticky bit per request line, set by a core event pulse and
 * cleared by the host acknowledge status
 */
module ext_req_reg (
	input  logic       clk_sys,
	input  logic       rst,
	input  logic [1:0] irq,
	input  logic [1:0] ack,
	output logic [1:0] req
);

	// bits that survive this cycle
	logic [1:0] req_keep;

	// an acknowledged bit drops unless a fresh event lands on it
	assign req_keep = req & ~ack;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			req <= 2'b00;
		end else begin
			// set wins over clear in the same cycle
			req <= req_keep | irq;
		end
	end

endmodule

//--- verilog/hps_ext.sv
`timescale 1ns/1ps
/*
 * host command decoder
 * turns 16-bit host words into 32-bit core memory reads and writes,
 * returns the core clock rate and request bits, and pulses the
 * acknowledge status into the core
 */
module hps_ext (
	input  logic               clk_sys,
	input  logic               rst,
	input  ext_pkg::host_req_t host_req,
	output ext_pkg::host_rsp_t host_rsp,
	input  logic [31:0]        clk_rate,
	output ext_pkg::ext_bus_t  ext_bus,
	input  logic [31:0]        rdata,
	input  logic               mem_wait,
	input  logic [1:0]         req,
	output logic [1:0]         status
);

	// channel level and command recognition
	logic        active;
	logic        cmd_ok;
	// word counter of the current command, word 0 is the command itself
	logic [9:0]  byte_cnt;
	logic [15:0] cmd;
	// low or high half of the next data word
	logic        hilo;
	// read completion tracking
	logic        old_wait;
	logic        pending;
	logic        rd_done;
	// registered outputs
	logic [15:0] dout;
	logic        dout_en;
	logic        busy;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic        rd;
	logic        wr;

	assign active = |host_req.enable;
	assign cmd_ok = (host_req.din >= ext_pkg::ext_cmd_min) &&
		(host_req.din <= ext_pkg::ext_cmd_max);

	// the memory has finished a read once wait drops with a read outstanding
	assign rd_done = old_wait & ~mem_wait & pending;

	assign host_rsp = '{dout: dout, dout_en: dout_en, busy: busy};
	assign ext_bus = '{addr: addr, dout: wdata, rd: rd, wr: wr};

	always_ff @(posedge clk_sys) begin
		// rd, wr and status only last for the cycle after their strobe
		rd <= 1'b0;
		wr <= 1'b0;
		status <= 2'b00;
		old_wait <= mem_wait;

		if (rst || !active) begin
			// a dropped enable aborts the command, same as reset
			byte_cnt <= '0;
			cmd <= '0;
			hilo <= 1'b0;
			old_wait <= 1'b0;
			pending <= 1'b0;
			dout <= '0;
			dout_en <= 1'b0;
		end else begin
			if (host_req.strobe) begin
				// every strobe replaces the reply, zero unless a command answers
				dout <= '0;
				// saturate so long blocks stay in the data phase
				if (!(&byte_cnt)) begin
					byte_cnt <= byte_cnt + 10'd1;
				end

				if (byte_cnt == 10'd0) begin
					cmd <= host_req.din;
					hilo <= 1'b0;
					dout_en <= cmd_ok;
				end else begin
					case (cmd)
						ext_pkg::ext_cmd_write: begin
							if (byte_cnt == 10'd1) begin
								addr[15:0] <= host_req.din;
								dout <= clk_rate[15:0];
							end else if (byte_cnt == 10'd2) begin
								addr[31:16] <= host_req.din;
								dout <= clk_rate[31:16];
							end else if (!hilo) begin
								// the first pair goes to the given address, later
								// pairs step one word on
								if (byte_cnt > 10'd4) begin
									addr <= addr + 32'd4;
								end
								wdata[15:0] <= host_req.din;
								hilo <= 1'b1;
							end else begin
								wdata[31:16] <= host_req.din;
								wr <= 1'b1;
								hilo <= 1'b0;
							end
						end

						ext_pkg::ext_cmd_read: begin
							if (byte_cnt == 10'd1) begin
								addr[15:0] <= host_req.din;
							end else if (byte_cnt == 10'd2) begin
								addr[31:16] <= host_req.din;
							end else if (!hilo) begin
								// low half strobe starts the memory read, the reply
								// arrives when wait falls
								rd <= 1'b1;
								pending <= 1'b1;
								hilo <= 1'b1;
							end else begin
								// high half comes straight from the held read word
								dout <= rdata[31:16];
								addr <= addr + 32'd4;
								hilo <= 1'b0;
							end
						end

						ext_pkg::ext_cmd_status: begin
							// report the pending requests and acknowledge the
							// ones named in the argument
							dout <= {14'd0, req};
							status <= host_req.din[1:0];
						end

						default: begin
							// unknown command, keep the reply at zero
						end
					endcase
				end
			end

			// load the low read half as soon as the memory lets go of wait
			if (rd_done) begin
				pending <= 1'b0;
				dout <= rdata[15:0];
			end
		end
	end

	// busy follows the memory wait level, rd covers the cycle before
	// the memory raises wait so the host never strobes into a read
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			busy <= 1'b0;
		end else begin
			busy <= mem_wait | rd;
		end
	end

endmodule

//--- verilog/hps_ext_sys.sv
`timescale 1ns/1ps
/*
 * host command channel top level
 * connects the host command decoder to the core memory and the
 * request register, status is brought out for the core
 */
module hps_ext_sys (
	input  logic               clk_sys,
	input  logic               rst,
	input  ext_pkg::host_req_t host_req,
	output ext_pkg::host_rsp_t host_rsp,
	input  logic [31:0]        clk_rate,
	input  logic [1:0]         irq,
	output logic [1:0]         status
);

	// decoder to memory
	ext_pkg::ext_bus_t ext_bus;
	// memory back to decoder
	logic [31:0] rdata;
	logic        mem_wait;
	// pending request bits seen by the host
	logic [1:0]  req;

	hps_ext u_hps_ext (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.host_req (host_req),
		.host_rsp (host_rsp),
		.clk_rate (clk_rate),
		.ext_bus  (ext_bus),
		.rdata    (rdata),
		.mem_wait (mem_wait),
		.req      (req),
		.status   (status)
	);

	ext_mem u_ext_mem (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.ext_bus  (ext_bus),
		.rdata    (rdata),
		.mem_wait (mem_wait)
	);

	// the status pulse doubles as the acknowledge for the request bits
	ext_req_reg u_ext_req_reg (
		.clk_sys (clk_sys),
		.rst     (rst),
		.irq     (irq),
		.ack     (status),
		.req     (req)
	);

endmodule

//--- vlog.f
+incdir+dv
verilog/ext_pkg.sv
verilog/ext_req_reg.sv
verilog/ext_mem.sv
verilog/hps_ext.sv
verilog/hps_ext_sys.sv
dv/tb_hps_ext_sys.sv
